/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= cache_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* cache_ctrl/cache_ctrl.sv */
// cache controller: main FSM, request register, lookup copies, victim toggle and bus drive
module cache_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    // processor side
    input  logic [cache_pkg::addr_w-1:0]  addr,
    input  logic [cache_pkg::word_w-1:0]  data_in,
    input  logic                          valid_in,
    input  logic                          write,
    input  cache_pkg::len_e               len,
    output logic                          addr_ok,
    output logic                          data_ok,
    // memory side
    input  logic                          r_rdy,
    input  logic                          re_valid,
    input  cache_pkg::line_t              re_data,
    input  logic                          w_rdy,
    output logic                          r_req,
    output logic [cache_pkg::addr_w-1:0]  r_addr,
    output logic                          w_req,
    output logic [cache_pkg::addr_w-1:0]  w_addr,
    output cache_pkg::line_t              w_data,
    // ways
    input  logic                          hit0,
    input  logic                          hit1,
    input  cache_pkg::tag_entry_t         tag0_rdata,
    input  cache_pkg::tag_entry_t         tag1_rdata,
    input  cache_pkg::line_t              line0_rdata,
    input  cache_pkg::line_t              line1_rdata,
    output logic [cache_pkg::index_w-1:0] index,
    output logic [cache_pkg::tag_w-1:0]   req_tag,
    output logic                          tag_we0,
    output logic                          tag_we1,
    output logic                          data_we0,
    output logic                          data_we1,
    output cache_pkg::tag_entry_t         tag_wdata,
    output cache_pkg::line_t              data_wdata,
    // line shifter
    output logic [cache_pkg::offs_w-1:0]  offset,
    output cache_pkg::len_e               req_len,
    output logic [cache_pkg::word_w-1:0]  req_word,
    output cache_pkg::line_t              base_line,
    output cache_pkg::line_t              read_line,
    input  cache_pkg::line_t              merged_line
);

    cache_pkg::state_e state_q;
    cache_pkg::state_e state_d;

    // held request
    logic [cache_pkg::addr_w-1:0]  addr_q;
    logic [cache_pkg::word_w-1:0]  data_q;
    cache_pkg::len_e               len_q;
    logic                          write_q;
    logic [cache_pkg::index_w-1:0] index_q;

    // lookup copies, used after the RAMs move on
    cache_pkg::tag_entry_t tag0_q;
    cache_pkg::tag_entry_t tag1_q;
    cache_pkg::line_t      line0_q;
    cache_pkg::line_t      line1_q;
    logic                  hit1_q;
    logic                  victim_q;  // way to replace on a miss

    logic                  hit;
    logic                  rd_hit;
    logic                  accept;
    logic                  refill_we;
    logic                  write_we;
    cache_pkg::tag_entry_t victim_tag;
    logic                  victim_dirty;

    assign index_q = addr_q[cache_pkg::offs_w +: cache_pkg::index_w];
    assign req_tag = addr_q[cache_pkg::addr_w-1 -: cache_pkg::tag_w];
    assign offset  = addr_q[cache_pkg::offs_w-1:0];

    ////////////////////
    // processor handshake
    assign hit     = hit0 | hit1;
    assign rd_hit  = (state_q == cache_pkg::st_lookup) && hit && !write_q;
    assign addr_ok = (state_q == cache_pkg::st_idle) || rd_hit;  // stream on read hits
    assign accept  = valid_in && addr_ok;
    assign data_ok = rd_hit || ((state_q == cache_pkg::st_refill) && re_valid && !write_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_q <= 1'b0;
        end else if (accept) begin
            write_q <= write;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= addr;
            data_q <= data_in;
            len_q  <= len;
        end
    end

    ////////////////////
    // main FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= cache_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            cache_pkg::st_idle: begin
                if (valid_in) state_d = cache_pkg::st_lookup;
            end
            cache_pkg::st_lookup: begin
                if (!hit)          state_d = cache_pkg::st_miss;
                else if (write_q)  state_d = cache_pkg::st_write;
                else if (valid_in) state_d = cache_pkg::st_lookup;  // next read taken
                else               state_d = cache_pkg::st_idle;
            end
            cache_pkg::st_miss: begin
                if (w_rdy || !victim_dirty) state_d = cache_pkg::st_replace;  // clean skips
            end
            cache_pkg::st_replace: begin
                if (r_rdy) state_d = cache_pkg::st_refill;
            end
            cache_pkg::st_refill: begin
                if (re_valid) state_d = cache_pkg::st_idle;
            end
            cache_pkg::st_write: state_d = cache_pkg::st_idle;
            default:             state_d = cache_pkg::st_idle;
        endcase
    end

    ////////////////////
    // lookup copies and victim
    always_ff @(posedge clk) begin
        if (state_q == cache_pkg::st_lookup) begin
            tag0_q  <= tag0_rdata;
            tag1_q  <= tag1_rdata;
            line0_q <= line0_rdata;
            line1_q <= line1_rdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit1_q   <= 1'b0;
            victim_q <= 1'b0;
        end else begin
            if (state_q == cache_pkg::st_lookup) hit1_q <= hit1;
            if (state_q == cache_pkg::st_idle) victim_q <= ~victim_q;  // cheap random
        end
    end

    assign victim_tag   = victim_q ? tag1_q : tag0_q;
    assign victim_dirty = victim_tag.dirty && victim_tag.valid;

    ////////////////////
    // memory channels, all full lines at offset 0
    assign w_req  = (state_q == cache_pkg::st_miss) && victim_dirty;
    assign w_addr = {victim_tag.tag, index_q, {cache_pkg::offs_w{1'b0}}};
    assign w_data = victim_q ? line1_q : line0_q;
    assign r_req  = state_q == cache_pkg::st_replace;
    assign r_addr = {req_tag, index_q, {cache_pkg::offs_w{1'b0}}};

    ////////////////////
    // way writes
    // incoming index while a new request may come in
    assign index = ((state_q == cache_pkg::st_idle) || (state_q == cache_pkg::st_lookup))
                 ? addr[cache_pkg::offs_w +: cache_pkg::index_w] : index_q;

    assign refill_we = (state_q == cache_pkg::st_refill) && re_valid;
    assign write_we  = state_q == cache_pkg::st_write;
    assign tag_we0   = (refill_we && !victim_q) || (write_we && !hit1_q);
    assign tag_we1   = (refill_we && victim_q) || (write_we && hit1_q);
    assign data_we0  = tag_we0;  // tag and line always move together
    assign data_we1  = tag_we1;

    assign tag_wdata  = '{dirty: write_q, valid: 1'b1, tag: req_tag};
    assign data_wdata = write_q ? merged_line : re_data;  // store lands in the line

    // shifter feed
    assign req_len   = len_q;
    assign req_word  = data_q;
    assign base_line = (state_q == cache_pkg::st_refill) ? re_data
                     : (hit1_q ? line1_q : line0_q);
    assign read_line = (state_q == cache_pkg::st_lookup) ? (hit1 ? line1_rdata : line0_rdata)
                     : re_data;

endmodule

/* cache_way/cache_way.sv */
// one cache way: tag RAM, data RAM and the hit compare against the held request tag
module cache_way #(
    parameter int depth = 64
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [$clog2(depth)-1:0]       index,
    input  logic [cache_pkg::tag_w-1:0]    req_tag,     // tag of the held request
    input  logic                           tag_we,
    input  cache_pkg::tag_entry_t          tag_wdata,
    input  logic                           data_we,
    input  cache_pkg::line_t               data_wdata,
    output cache_pkg::tag_entry_t          tag_rdata,
    output cache_pkg::line_t               line_rdata,
    output logic                           hit
);

    //////////////////// storage
    // read every cycle, the controller picks what it needs
    way_ram #(
        .entry_t (cache_pkg::tag_entry_t),
        .depth   (depth)
    ) tag_ram_i (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (1'b1),
        .we    (tag_we),
        .addr  (index),
        .wdata (tag_wdata),
        .rdata (tag_rdata)
    );

    way_ram #(
        .entry_t (cache_pkg::line_t),
        .depth   (depth)
    ) data_ram_i (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (1'b1),
        .we    (data_we),   // whole line, merge done upstream
        .addr  (index),
        .wdata (data_wdata),
        .rdata (line_rdata)
    );

    //////////////////// compare
    // RAM output belongs to the request taken on the last edge
    assign hit = tag_rdata.valid && (tag_rdata.tag == req_tag);

endmodule

/* cache_way/way_ram.sv */
// synchronous single-port RAM with registered read and a type parameter for the entry
module way_ram #(
    parameter type entry_t = logic [7:0],
    parameter int  depth   = 64
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     en,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] addr,
    input  entry_t                   wdata,
    output entry_t                   rdata
);

    entry_t mem [depth];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;  // all entries invalid
            end
            rdata <= '0;
        end else if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];  // old contents on a write cycle
        end
    end

endmodule

/* common/cache_pkg.sv */
// cache geometry, line and tag entry types, store length and controller state codes
package cache_pkg;

    //////////////////// widths
    parameter int addr_w  = 32;   // processor and memory address
    parameter int word_w  = 64;   // processor data
    parameter int line_w  = 256;  // one line, also the memory bus width

    // address split: tag | index | offset
    parameter int offs_w  = 5;    // byte within a 32 byte line
    parameter int index_w = 6;
    parameter int tag_w   = addr_w - index_w - offs_w;  // 21

    parameter int sets    = 64;   // lines per way

    //////////////////// storage types
    typedef logic [line_w-1:0] line_t;

    // one tag RAM word, dirty on top as in the old layout
    typedef struct packed {
        logic             dirty;
        logic             valid;
        logic [tag_w-1:0] tag;
    } tag_entry_t;  // 23 bits

    //////////////////// codes
    // store size, matches the processor len field
    typedef enum logic [1:0] {
        len_byte   = 2'd0,
        len_half   = 2'd1,
        len_word   = 2'd2,
        len_double = 2'd3
    } len_e;

    // main FSM
    typedef enum logic [2:0] {
        st_idle    = 3'd0,  // waiting for a request
        st_lookup  = 3'd1,  // tag compare on RAM output
        st_miss    = 3'd2,  // victim write-back when dirty
        st_replace = 3'd3,  // line read request
        st_refill  = 3'd4,  // waiting for the line
        st_write   = 3'd5   // store hit, merged line goes in
    } state_e;

endpackage

/* hdl/cache_top.sv */
// cache top level: controller, two ways and the line shifter wired together
module cache_top #(
    parameter int depth = cache_pkg::sets
) (
    input  logic                         clk,
    input  logic                         rst_n,
    // processor side
    input  logic [cache_pkg::addr_w-1:0] addr,
    input  logic [cache_pkg::word_w-1:0] data_in,
    input  logic                         valid_in,
    input  logic                         write,
    input  cache_pkg::len_e              len,
    output logic                         addr_ok,
    output logic                         data_ok,
    output logic [cache_pkg::word_w-1:0] data_out,
    // read channel
    output logic                         r_req,
    output logic [cache_pkg::addr_w-1:0] r_addr,
    input  logic                         r_rdy,
    input  logic                         re_valid,
    input  cache_pkg::line_t             re_data,
    // write channel
    output logic                         w_req,
    output logic [cache_pkg::addr_w-1:0] w_addr,
    output cache_pkg::line_t             w_data,
    input  logic                         w_rdy
);

    logic [cache_pkg::index_w-1:0] index;
    logic [cache_pkg::tag_w-1:0]   req_tag;
    logic                          tag_we0;
    logic                          tag_we1;
    logic                          data_we0;
    logic                          data_we1;
    cache_pkg::tag_entry_t         tag_wdata;
    cache_pkg::line_t              data_wdata;
    cache_pkg::tag_entry_t         tag0_rdata;
    cache_pkg::tag_entry_t         tag1_rdata;
    cache_pkg::line_t              line0_rdata;
    cache_pkg::line_t              line1_rdata;
    logic                          hit0;
    logic                          hit1;

    // shifter path
    logic [cache_pkg::offs_w-1:0]  offset;
    cache_pkg::len_e               req_len;
    logic [cache_pkg::word_w-1:0]  req_word;
    cache_pkg::line_t              base_line;
    cache_pkg::line_t              read_line;
    cache_pkg::line_t              merged_line;

    cache_ctrl ctrl_i (
        .clk, .rst_n,
        .addr, .data_in, .valid_in, .write, .len, .addr_ok, .data_ok,
        .r_rdy, .re_valid, .re_data, .w_rdy, .r_req, .r_addr, .w_req, .w_addr, .w_data,
        .hit0, .hit1, .tag0_rdata, .tag1_rdata, .line0_rdata, .line1_rdata,
        .index, .req_tag, .tag_we0, .tag_we1, .data_we0, .data_we1, .tag_wdata, .data_wdata,
        .offset, .req_len, .req_word, .base_line, .read_line, .merged_line
    );

    //////////////////// ways
    cache_way #(.depth(depth)) way0_i (
        .clk, .rst_n, .index, .req_tag,
        .tag_we     (tag_we0),
        .tag_wdata,
        .data_we    (data_we0),
        .data_wdata,
        .tag_rdata  (tag0_rdata),
        .line_rdata (line0_rdata),
        .hit        (hit0)
    );

    cache_way #(.depth(depth)) way1_i (
        .clk, .rst_n, .index, .req_tag,
        .tag_we     (tag_we1),
        .tag_wdata,
        .data_we    (data_we1),
        .data_wdata,
        .tag_rdata  (tag1_rdata),
        .line_rdata (line1_rdata),
        .hit        (hit1)
    );

    // load word straight out to the processor
    line_shift shift_i (
        .offset, .store_word (req_word), .base_line, .read_line,
        .len         (req_len),
        .load_word   (data_out),
        .merged_line
    );

endmodule

/* hdl/line_shift.sv */
// line read-out shift to one word, and byte-masked merge of store data into a line
module line_shift (
    input  logic [cache_pkg::offs_w-1:0] offset,
    input  cache_pkg::len_e              len,
    input  logic [cache_pkg::word_w-1:0] store_word,
    input  cache_pkg::line_t             base_line,
    input  cache_pkg::line_t             read_line,
    output logic [cache_pkg::word_w-1:0] load_word,
    output cache_pkg::line_t             merged_line
);

    logic [cache_pkg::offs_w+2:0] bit_shift;  // offset in bits
    cache_pkg::line_t             shifted;
    cache_pkg::line_t             len_mask;
    cache_pkg::line_t             byte_mask;
    cache_pkg::line_t             store_line;

    assign bit_shift = {offset, 3'b000};

    // load, zeros come in past the line end
    assign shifted   = read_line >> bit_shift;
    assign load_word = shifted[cache_pkg::word_w-1:0];

    ////////////////////
    // store merge
    always_comb begin
        case (len)
            cache_pkg::len_byte: len_mask = cache_pkg::line_t'(8'hff);
            cache_pkg::len_half: len_mask = cache_pkg::line_t'(16'hffff);
            cache_pkg::len_word: len_mask = cache_pkg::line_t'(32'hffff_ffff);
            default:             len_mask = cache_pkg::line_t'(64'hffff_ffff_ffff_ffff);
        endcase
    end

    assign byte_mask  = len_mask << bit_shift;  // top bytes drop off at the line end
    assign store_line = cache_pkg::line_t'(store_word) << bit_shift;

    assign merged_line = (base_line & ~byte_mask) | (store_line & byte_mask);

endmodule

/* tests/cache_properties.sv */
// concurrent checks on the memory-bus request channels and the processor data_ok output
module cache_properties (
    input logic        clk,
    input logic        rst_n,
    input logic        r_req,
    input logic        r_rdy,
    input logic [31:0] r_addr,
    input logic        w_req,
    input logic        w_rdy,
    input logic [31:0] w_addr,
    input logic        data_ok
);

    //////////////////// bus channels
    // one channel at a time
    req_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(r_req && w_req))
        else $error("r_req and w_req high together");

    // read request held until r_rdy
    r_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (r_req && !r_rdy) |=> (r_req && $stable(r_addr)))
        else $error("r_req or r_addr changed before r_rdy");

    // write request held until w_rdy
    w_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (w_req && !w_rdy) |=> (w_req && $stable(w_addr)))
        else $error("w_req or w_addr changed before w_rdy");

    //////////////////// reset release
    ok_quiet_after_release: assert property (@(posedge clk)
        $rose(rst_n) |=> !data_ok)
        else $error("data_ok high in the cycle after reset release");

endmodule

/* tests/cache_tb.sv */
// testbench: clock, reset, processor stimulus, memory model, reference load and result compare
module cache_tb;

    logic                  clk;
    logic                  rst_n;
    logic [31:0]           addr;
    logic [63:0]           data_in;
    logic                  valid_in;
    logic                  write;
    cache_pkg::len_e       len;
    logic                  addr_ok;
    logic                  data_ok;
    logic [63:0]           data_out;
    logic                  r_req;
    logic [31:0]           r_addr;
    logic                  r_rdy;
    logic                  re_valid;
    cache_pkg::line_t      re_data;
    logic                  w_req;
    logic [31:0]           w_addr;
    cache_pkg::line_t      w_data;
    logic                  w_rdy;

    int errors = 0;
    int tests = 0;
    int failed = 0;
    int cycle = 0;

    // expected reads in accept order
    logic [63:0] exp_q [$];
    int          acc_q [$];
    bit          lat_q [$];
    logic [63:0] exp_d;
    int          acc_c;
    bit          lat_c;

    // memory model state
    cache_pkg::line_t mem [logic [31:0]];
    logic [7:0]       gold [logic [31:0]];  // processor view, byte addressed
    int               r_delay = -1;
    int               re_delay = 0;
    bit               rd_busy = 1'b0;
    logic [31:0]      rd_addr = '0;
    int               stall_left = 0;
    int               stall_w_seen = 0;
    int               stall_r_seen = 0;
    int               wb_count = 0;
    logic             prev_r_req = 1'b0;
    logic             prev_r_rdy = 1'b0;
    logic [31:0]      prev_r_addr = '0;
    logic             prev_w_req = 1'b0;
    logic             prev_w_rdy = 1'b0;
    logic [31:0]      prev_w_addr = '0;

    cache_top #(.depth(cache_pkg::sets)) dut_i (.*);

    bind cache_ctrl cache_properties props_i (
        .clk(clk), .rst_n(rst_n), .r_req(r_req), .r_rdy(r_rdy), .r_addr(r_addr),
        .w_req(w_req), .w_rdy(w_rdy), .w_addr(w_addr), .data_ok(data_ok)
    );

    always #10 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    //////////////////// reference model
    // untouched memory, hashed from the whole byte address
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        logic [31:0] h;
        h = a * 32'h9e37_79b1;
        return h[31:24] ^ a[7:0];
    endfunction

    function automatic logic [7:0] golden_byte(input logic [31:0] a);
        if (gold.exists(a)) return gold[a];
        return fill_byte(a);
    endfunction

    function automatic cache_pkg::line_t golden_line(input logic [31:0] la);
        cache_pkg::line_t l;
        for (int i = 0; i < 32; i++) l[8*i +: 8] = golden_byte(la + 32'(i));
        return l;
    endfunction

    function automatic cache_pkg::line_t mem_line(input logic [31:0] la);
        cache_pkg::line_t l;
        if (mem.exists(la)) return mem[la];
        for (int i = 0; i < 32; i++) l[8*i +: 8] = fill_byte(la + 32'(i));
        return l;
    endfunction

    // bytes from a upward, zero past the line end
    function automatic logic [63:0] expected_load(input logic [31:0] a);
        logic [63:0] w;
        w = '0;
        for (int i = 0; i < 8; i++) begin
            if (int'(a[4:0]) + i < 32) w[8*i +: 8] = golden_byte(a + 32'(i));
        end
        return w;
    endfunction

    task automatic store_golden(input logic [31:0] a, input cache_pkg::len_e l,
                                input logic [63:0] d);
        int n;
        n = 1 << int'(l);
        for (int i = 0; i < n; i++) begin
            if (int'(a[4:0]) + i < 32) gold[a + 32'(i)] = d[8*i +: 8];  // cut at line end
        end
    endtask

    function automatic logic [31:0] line_addr(input int t, input int idx);
        return {21'(t), 6'(idx), 5'd0};
    endfunction

    //////////////////// processor side
    // drive one request and hold it until accepted
    task automatic issue(input logic [31:0] a, input logic wr, input cache_pkg::len_e l,
                         input logic [63:0] d, input bit lat);
        int waited;
        bit got;
        waited = 0;
        got = 1'b0;
        @(negedge clk);
        addr = a;
        write = wr;
        len = l;
        data_in = d;
        valid_in = 1'b1;
        while (!got && waited < 500) begin
            @(posedge clk);
            got = addr_ok;
            waited++;
        end
        if (!got) begin
            errors++;
            $display("timeout: request at %h never accepted", a);
            $display("Something failed");
            $finish;
        end else if (wr) begin
            store_golden(a, l, d);
        end else begin
            exp_q.push_back(expected_load(a));
            acc_q.push_back(cycle);
            lat_q.push_back(lat);
        end
    endtask

    // drop valid and wait for idle with no read outstanding
    task automatic drain();
        int waited;
        bit done;
        waited = 0;
        done = 1'b0;
        @(negedge clk);
        valid_in = 1'b0;
        while (!done && waited < 2000) begin
            @(posedge clk);
            done = addr_ok && !data_ok && (exp_q.size() == 0);
            waited++;
        end
        if (!done) begin
            errors++;
            $display("timeout: cache did not return to idle with all reads answered");
            $display("Something failed");
            $finish;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: %0d errors", tests, name, errors - err_before);
        end
    endtask

    //////////////////// compare
    always @(posedge clk) begin
        if (rst_n && data_ok) begin
            assert (exp_q.size() > 0) else begin
                $display("unexpected data_ok at time %0t with no read outstanding", $time);
                errors++;
            end
            if (exp_q.size() > 0) begin
                exp_d = exp_q.pop_front();
                acc_c = acc_q.pop_front();
                lat_c = lat_q.pop_front();
                assert (data_out === exp_d) else begin
                    $display("[ERROR] %0t: data_out %h, expected %h", $time, data_out, exp_d);
                    errors++;
                end
                if (lat_c) begin
                    assert (cycle == acc_c + 1) else begin
                        $display("[ERROR] %0t: hit latency %0d cycles", $time, cycle - acc_c);
                        errors++;
                    end
                end
            end
        end
    end

    //////////////////// memory model
    always @(negedge clk) begin
        if (!rst_n) begin
            r_rdy = 1'b0;
            w_rdy = 1'b0;
            re_valid = 1'b0;
        end else begin
            // held requests must not move
            if (prev_r_req && !prev_r_rdy) begin
                assert (r_req && r_addr == prev_r_addr) else begin
                    $display("[ERROR] %0t: read request dropped or moved", $time);
                    errors++;
                end
            end
            if (prev_w_req && !prev_w_rdy) begin
                assert (w_req && w_addr == prev_w_addr) else begin
                    $display("[ERROR] %0t: write request dropped or moved", $time);
                    errors++;
                end
            end
            r_rdy = 1'b0;
            w_rdy = 1'b0;
            re_valid = 1'b0;
            if (rd_busy) begin
                if (re_delay == 0) begin
                    re_valid = 1'b1;  // whole line in one beat
                    re_data = mem_line(rd_addr);
                    rd_busy = 1'b0;
                end else begin
                    re_delay--;
                end
            end
            if (stall_left > 0) begin
                stall_left--;
                if (w_req) stall_w_seen++;
                if (r_req) stall_r_seen++;
            end else begin
                if (w_req && ($urandom % 3 != 0)) begin
                    assert (w_data === golden_line(w_addr) && w_addr[4:0] == 5'd0) else begin
                        $display("[ERROR] %0t: write-back of %h differs from golden line",
                                 $time, w_addr);
                        errors++;
                    end
                    mem[w_addr] = w_data;
                    wb_count++;
                    w_rdy = 1'b1;
                end
                if (r_req && !rd_busy) begin
                    if (r_delay < 0) r_delay = int'($urandom % 4);
                    if (r_delay == 0) begin
                        r_rdy = 1'b1;
                        rd_busy = 1'b1;
                        rd_addr = r_addr;
                        re_delay = int'($urandom % 4);
                        r_delay = -1;
                    end else begin
                        r_delay--;
                    end
                end
            end
            prev_r_req = r_req;
            prev_r_rdy = r_rdy;
            prev_r_addr = r_addr;
            prev_w_req = w_req;
            prev_w_rdy = w_rdy;
            prev_w_addr = w_addr;
        end
    end

    //////////////////// tests
    initial begin
        logic [31:0] a;
        int          e0;
        int          wb0;
        void'($urandom(32'hb170_5a29));
        clk = 1'b0;
        rst_n = 1'b0;
        addr = '0;
        data_in = '0;
        valid_in = 1'b0;
        write = 1'b0;
        len = cache_pkg::len_byte;
        r_rdy = 1'b0;
        re_valid = 1'b0;
        re_data = '0;
        w_rdy = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // cold miss, line aligned request
        e0 = errors;
        issue(32'h0000_1013, 1'b0, cache_pkg::len_double, '0, 1'b0);
        drain();
        assert (rd_addr == 32'h0000_1000) else begin
            $display("[ERROR] %0t: r_addr %h, expected 00001000", $time, rd_addr);
            errors++;
        end
        finish_test("cold read miss", e0);

        // hits, single then streamed
        e0 = errors;
        issue(32'h0000_1000, 1'b0, cache_pkg::len_double, '0, 1'b1);
        drain();
        issue(32'h0000_1008, 1'b0, cache_pkg::len_double, '0, 1'b1);
        issue(32'h0000_1010, 1'b0, cache_pkg::len_double, '0, 1'b1);
        issue(32'h0000_1003, 1'b0, cache_pkg::len_double, '0, 1'b1);
        issue(32'h0000_101c, 1'b0, cache_pkg::len_double, '0, 1'b1);
        drain();
        finish_test("read hit latency", e0);

        // mixed stores and loads over four lines
        e0 = errors;
        for (int k = 0; k < 60; k++) begin
            a = 32'h0004_0000 + ($urandom % 4) * 32 + ($urandom % 32);
            if ($urandom % 2 == 0) begin
                issue(a, 1'b1, cache_pkg::len_e'(2'($urandom % 4)), {$urandom, $urandom}, 1'b0);
            end else begin
                issue(a, 1'b0, cache_pkg::len_double, '0, 1'b0);
            end
        end
        for (int k = 0; k < 4; k++) begin
            for (int off = 24; off < 32; off++) begin
                issue(32'h0004_0000 + 32'(k * 32 + off), 1'b0, cache_pkg::len_double, '0, 1'b0);
            end
        end
        drain();
        finish_test("store lengths", e0);

        // three tags on one set force a dirty eviction
        e0 = errors;
        wb0 = wb_count;
        for (int t = 1; t <= 3; t++) begin
            issue(line_addr(t, 9) + 8, 1'b1, cache_pkg::len_double, {$urandom, $urandom}, 1'b0);
            drain();
        end
        for (int t = 1; t <= 3; t++) begin
            issue(line_addr(t, 9) + 8, 1'b0, cache_pkg::len_double, '0, 1'b0);
            drain();
        end
        assert (wb_count > wb0) else begin
            $display("no write-back seen while evicting dirty lines");
            errors++;
        end
        finish_test("eviction and write-back", e0);

        // long back-pressure on both channels
        e0 = errors;
        issue(line_addr(5, 12), 1'b1, cache_pkg::len_word, {$urandom, $urandom}, 1'b0);
        issue(line_addr(6, 12) + 4, 1'b1, cache_pkg::len_half, {$urandom, $urandom}, 1'b0);
        drain();
        stall_left = 40;
        issue(line_addr(7, 12) + 30, 1'b1, cache_pkg::len_double, {$urandom, $urandom}, 1'b0);
        drain();
        stall_left = 40;
        issue(line_addr(8, 13) + 5, 1'b0, cache_pkg::len_double, '0, 1'b0);  // cold set
        drain();
        for (int t = 5; t <= 7; t++) begin
            issue(line_addr(t, 12), 1'b0, cache_pkg::len_double, '0, 1'b0);
            issue(line_addr(t, 12) + 28, 1'b0, cache_pkg::len_double, '0, 1'b0);
        end
        drain();
        assert (stall_w_seen > 0) else begin
            $display("write request never seen during the stall");
            errors++;
        end
        assert (stall_r_seen > 0) else begin
            $display("read request never seen during the stall");
            errors++;
        end
        finish_test("stall with back-pressure", e0);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
common/cache_pkg.sv
cache_way/way_ram.sv
cache_way/cache_way.sv
cache_ctrl/cache_ctrl.sv
hdl/line_shift.sv
hdl/cache_top.sv
tests/cache_properties.sv
tests/cache_tb.sv
